// ==== verif/dp_stim.txt ====
# src wr_en wr_addr y hi lo z pc_en pc_inc mar_en mdr_en mdr_read op m_data wait check
# then expected zhi zlo mar, every field in hex
16 0 0 0 0 0 0 0 0 0 0 0 0 00000000 0 1 00000000 00000000 00000000
16 0 0 0 0 0 0 0 0 0 1 1 0 9abcdef0 0 0 00000000 00000000 00000000
15 1 4 0 0 0 0 0 0 0 1 1 0 12345678 0 0 00000000 00000000 00000000
15 1 5 0 0 0 0 0 0 0 0 0 0 00000000 0 0 00000000 00000000 00000000
04 0 0 1 0 0 0 0 0 0 0 0 0 00000000 0 0 00000000 00000000 00000000
05 0 0 0 0 0 1 0 0 0 0 0 0 00000000 0 1 00000000 acf13568 00000000
05 0 0 0 0 0 1 0 0 0 0 0 1 00000000 0 1 00000000 88888878 00000000
05 0 0 0 0 0 1 0 0 0 0 0 2 00000000 0 1 00000000 12345670 00000000
05 0 0 0 0 0 1 0 0 0 0 0 3 00000000 0 1 00000000 9abcdef8 00000000
05 0 0 0 0 0 1 0 0 0 0 0 4 00000000 0 1 00000000 f0000000 00000000
05 0 0 0 0 0 1 0 0 0 0 0 5 00000000 0 1 00000000 0000009a 00000000
05 0 0 0 0 0 1 0 0 0 0 0 6 00000000 0 1 00000000 edcba988 00000000
05 0 0 0 0 0 1 0 0 0 0 0 7 00000000 0 1 00000000 edcba987 00000000
16 0 0 0 0 0 0 0 0 0 1 1 0 ffffff38 0 0 00000000 00000000 00000000
15 1 4 0 0 0 0 0 0 0 1 1 0 0001e240 0 0 00000000 00000000 00000000
15 1 5 0 0 0 0 0 0 0 0 0 0 00000000 0 0 00000000 00000000 00000000
04 0 0 1 0 0 0 0 0 0 0 0 0 00000000 0 0 00000000 00000000 00000000
05 0 0 0 0 0 1 0 0 0 0 0 8 00000000 0 1 ffffffff fe873e00 00000000
16 0 0 0 0 0 0 0 0 0 1 1 0 ffffff9c 0 0 00000000 00000000 00000000
15 0 0 1 0 0 0 0 0 0 1 1 0 00000007 0 0 00000000 00000000 00000000
15 0 0 0 0 0 1 0 0 0 0 0 9 00000000 1 0 00000000 00000000 00000000
16 0 0 0 0 0 0 0 0 0 0 0 0 00000000 0 1 fffffffe fffffff2 00000000
16 0 0 0 0 0 1 0 0 0 0 0 9 00000000 1 0 00000000 00000000 00000000
16 0 0 0 0 0 0 0 0 0 0 0 0 00000000 0 1 ffffff9c ffffffff 00000000
16 0 0 0 0 0 0 0 1 0 0 0 0 00000000 0 0 00000000 00000000 00000000
16 0 0 0 0 0 0 0 1 0 0 0 0 00000000 0 0 00000000 00000000 00000000
14 0 0 0 0 0 0 0 0 1 0 0 0 00000000 0 1 ffffff9c ffffffff 00000008
16 0 0 0 0 0 0 0 0 0 1 1 0 00400100 0 0 00000000 00000000 00000000
15 0 0 0 0 0 0 1 1 0 0 0 0 00000000 0 0 00000000 00000000 00000000
16 0 0 0 0 0 0 0 1 0 0 0 0 00000000 0 0 00000000 00000000 00000000
14 0 0 0 0 0 0 0 0 1 0 0 0 00000000 0 1 ffffff9c ffffffff 00400104
16 0 0 0 0 0 0 0 0 0 1 1 0 0badc0de 0 0 00000000 00000000 00000000
15 1 0 0 0 0 0 0 0 0 1 1 0 5eed1e55 0 0 00000000 00000000 00000000
15 1 f 0 0 0 0 0 0 0 0 0 0 00000000 0 0 00000000 00000000 00000000
0f 0 0 0 0 0 0 0 0 1 0 0 0 00000000 0 1 ffffff9c ffffffff 5eed1e55
00 0 0 0 0 0 0 0 0 1 0 0 0 00000000 0 1 ffffff9c ffffffff 0badc0de

// ==== all.f ====
design/bus_pkg.sv
design/alu_pkg.sv
design/gp_reg_slice.sv
design/bus_mux.sv
design/special_regs.sv
design/mul_div_alu.sv
design/mul_div_datapath.sv
verif/dp_checker.sv
verif/tb_mul_div_datapath.sv

// ==== verif/tb_mul_div_datapath.sv ====
module tb_mul_div_datapath;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_GP_REGS = 16;
    localparam int MAX_LINES = 1000;
    localparam int BUSY_TIMEOUT = 100;
    localparam int NUM_FIELDS = 19;

    logic clk = 1'b0;
    logic rst_n;
    bus_pkg::bus_src_e bus_src;
    logic gp_wr_en;
    logic [bus_pkg::GP_ADDR_WIDTH-1:0] gp_wr_addr;
    logic y_enable;
    logic hi_enable;
    logic lo_enable;
    logic z_enable;
    logic pc_enable;
    logic pc_increment;
    logic mar_enable;
    logic mdr_enable;
    logic mdr_read;
    alu_pkg::alu_op_e op_code;
    logic [bus_pkg::DATA_WIDTH-1:0] m_data_in;
    logic [bus_pkg::DATA_WIDTH-1:0] zhi_data;
    logic [bus_pkg::DATA_WIDTH-1:0] zlo_data;
    logic [bus_pkg::DATA_WIDTH-1:0] mar_data;
    logic alu_busy;

    // expected values handed to the checker
    logic chk_valid = 1'b0;
    logic [bus_pkg::DATA_WIDTH-1:0] exp_zhi = '0;
    logic [bus_pkg::DATA_WIDTH-1:0] exp_zlo = '0;
    logic [bus_pkg::DATA_WIDTH-1:0] exp_mar = '0;
    int mismatch_count;
    int check_count;
    int timeout_count = 0;
    int other_errors = 0;

    // one parsed stimulus line
    logic [31:0] fields [NUM_FIELDS];

    always #4 clk = ~clk;

    mul_div_datapath #(
        .NUM_GP_REGS(NUM_GP_REGS)
    ) dut_i (.*);

    dp_checker chk_i (
        .clk(clk),
        .chk_valid(chk_valid),
        .exp_zhi(exp_zhi),
        .exp_zlo(exp_zlo),
        .exp_mar(exp_mar),
        .zhi_data(zhi_data),
        .zlo_data(zlo_data),
        .mar_data(mar_data),
        .alu_busy(alu_busy),
        .mismatch_count(mismatch_count),
        .check_count(check_count)
    );

    task set_idle;
        bus_src <= bus_pkg::SRC_NONE;
        gp_wr_en <= 1'b0;
        gp_wr_addr <= '0;
        y_enable <= 1'b0;
        hi_enable <= 1'b0;
        lo_enable <= 1'b0;
        z_enable <= 1'b0;
        pc_enable <= 1'b0;
        pc_increment <= 1'b0;
        mar_enable <= 1'b0;
        mdr_enable <= 1'b0;
        mdr_read <= 1'b0;
        op_code <= alu_pkg::OP_ADD;
        m_data_in <= '0;
        chk_valid <= 1'b0;
    endtask

    task apply_fields;
        bus_src <= bus_pkg::bus_src_e'(fields[0][4:0]);
        gp_wr_en <= fields[1][0];
        gp_wr_addr <= fields[2][bus_pkg::GP_ADDR_WIDTH-1:0];
        y_enable <= fields[3][0];
        hi_enable <= fields[4][0];
        lo_enable <= fields[5][0];
        z_enable <= fields[6][0];
        pc_enable <= fields[7][0];
        pc_increment <= fields[8][0];
        mar_enable <= fields[9][0];
        mdr_enable <= fields[10][0];
        mdr_read <= fields[11][0];
        op_code <= alu_pkg::alu_op_e'(fields[12][4:0]);
        m_data_in <= fields[13];
        chk_valid <= fields[15][0];
        exp_zhi <= fields[16];
        exp_zlo <= fields[17];
        exp_mar <= fields[18];
    endtask

    // drop the start request after one cycle, then wait for busy to fall
    task automatic wait_not_busy;
        int cycles;
        cycles = 0;
        @(posedge clk);
        set_idle();
        do begin
            @(posedge clk);
            cycles++;
        end while (alu_busy && cycles < BUSY_TIMEOUT);
        if (alu_busy) begin
            $display("timeout: divider still busy after %0d cycles", BUSY_TIMEOUT);
            timeout_count++;
        end
    endtask

    initial begin
        int fd;
        int n;
        int lines_read;
        string line;
        bit done;
        done = 1'b0;
        lines_read = 0;
        rst_n <= 1'b0;
        set_idle();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("verif/dp_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/dp_stim.txt");
            other_errors++;
            done = 1'b1;
        end
        while (!done && lines_read < MAX_LINES) begin
            lines_read++;
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                    fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
                    fields[12], fields[13], fields[14], fields[15], fields[16],
                    fields[17], fields[18]);
                if (n != NUM_FIELDS) begin
                    $display("stimulus line %0d has %0d fields instead of %0d",
                        lines_read, n, NUM_FIELDS);
                    other_errors++;
                end else begin
                    @(posedge clk);
                    apply_fields();
                    if (fields[14][0]) begin
                        wait_not_busy();
                    end
                    if (timeout_count != 0) begin
                        done = 1'b1;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        // let the last checked step reach the checker
        @(posedge clk);
        set_idle();
        repeat (3) @(posedge clk);
        if (check_count == 0) begin
            $display("no compares were made");
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other, %0d compares",
            mismatch_count, timeout_count, other_errors, check_count);
        if (mismatch_count == 0 && timeout_count == 0 && other_errors == 0
                && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verif/dp_checker.sv ====
module dp_checker (
    input  logic clk,
    input  logic chk_valid,
    input  logic [bus_pkg::DATA_WIDTH-1:0] exp_zhi,
    input  logic [bus_pkg::DATA_WIDTH-1:0] exp_zlo,
    input  logic [bus_pkg::DATA_WIDTH-1:0] exp_mar,
    input  logic [bus_pkg::DATA_WIDTH-1:0] zhi_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] zlo_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] mar_data,
    input  logic alu_busy,
    output int mismatch_count,
    output int check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // cycles a divide holds busy high
    localparam int DIV_BUSY_CYCLES = bus_pkg::DATA_WIDTH;

    // a checked step is compared one edge after it took effect
    logic pending_q = 1'b0;
    logic [bus_pkg::DATA_WIDTH-1:0] exp_zhi_q;
    logic [bus_pkg::DATA_WIDTH-1:0] exp_zlo_q;
    logic [bus_pkg::DATA_WIDTH-1:0] exp_mar_q;

    // length of the current busy pulse
    int busy_cycles = 0;

    task automatic compare_word(
        input string name,
        input logic [bus_pkg::DATA_WIDTH-1:0] expected,
        input logic [bus_pkg::DATA_WIDTH-1:0] actual
    );
        check_count++;
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%08h, got 0x%08h at %0t",
                name, expected, actual, $time);
            mismatch_count++;
        end
    endtask

    always @(posedge clk) begin
        if (pending_q) begin
            compare_word("zhi_data", exp_zhi_q, zhi_data);
            compare_word("zlo_data", exp_zlo_q, zlo_data);
            compare_word("mar_data", exp_mar_q, mar_data);
            // checked steps only come while the ALU is idle
            compare_word("alu_busy", '0, {{(bus_pkg::DATA_WIDTH-1){1'b0}}, alu_busy});
        end
        pending_q <= chk_valid;
        exp_zhi_q <= exp_zhi;
        exp_zlo_q <= exp_zlo;
        exp_mar_q <= exp_mar;
    end

    // one busy cycle per divider step
    always @(posedge clk) begin
        if (alu_busy) begin
            busy_cycles <= busy_cycles + 1;
        end else if (busy_cycles != 0) begin
            compare_word("alu_busy cycles", DIV_BUSY_CYCLES, busy_cycles);
            busy_cycles <= 0;
        end
    end

endmodule

// ==== design/mul_div_datapath.sv ====
module mul_div_datapath #(
    parameter int NUM_GP_REGS = bus_pkg::MAX_GP_REGS
) (
    input  logic clk,
    input  logic rst_n,
    input  bus_pkg::bus_src_e bus_src,
    input  logic gp_wr_en,
    input  logic [bus_pkg::GP_ADDR_WIDTH-1:0] gp_wr_addr,
    input  logic y_enable,
    input  logic hi_enable,
    input  logic lo_enable,
    input  logic z_enable,
    input  logic pc_enable,
    input  logic pc_increment,
    input  logic mar_enable,
    input  logic mdr_enable,
    input  logic mdr_read,
    input  alu_pkg::alu_op_e op_code,
    input  logic [bus_pkg::DATA_WIDTH-1:0] m_data_in,
    output logic [bus_pkg::DATA_WIDTH-1:0] zhi_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] zlo_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] mar_data,
    output logic alu_busy
);

    // shared bus
    logic [bus_pkg::DATA_WIDTH-1:0] bus_data;

    // masked register outputs toward the bus mux
    logic [bus_pkg::DATA_WIDTH-1:0] slice_out [NUM_GP_REGS];

    logic [bus_pkg::DATA_WIDTH-1:0] y_data;
    logic [bus_pkg::DATA_WIDTH-1:0] hi_data;
    logic [bus_pkg::DATA_WIDTH-1:0] lo_data;
    logic [bus_pkg::DATA_WIDTH-1:0] pc_data;
    logic [bus_pkg::DATA_WIDTH-1:0] mdr_data;

    for (genvar i = 0; i < NUM_GP_REGS; i++) begin : g_gp_regs
        gp_reg_slice #(
            .REG_INDEX(i)
        ) slice_i (
            .clk(clk),
            .rst_n(rst_n),
            .wr_en(gp_wr_en),
            .wr_addr(gp_wr_addr),
            .bus_src(bus_src),
            .bus_data(bus_data),
            .slice_out(slice_out[i])
        );
    end

    bus_mux #(
        .NUM_GP_REGS(NUM_GP_REGS)
    ) bus_mux_i (
        .slice_out(slice_out),
        .hi_data(hi_data),
        .lo_data(lo_data),
        .zhi_data(zhi_data),
        .zlo_data(zlo_data),
        .pc_data(pc_data),
        .mdr_data(mdr_data),
        .bus_src(bus_src),
        .bus_data(bus_data)
    );

    special_regs special_regs_i (
        .clk(clk),
        .rst_n(rst_n),
        .bus_data(bus_data),
        .y_enable(y_enable),
        .hi_enable(hi_enable),
        .lo_enable(lo_enable),
        .pc_enable(pc_enable),
        .pc_increment(pc_increment),
        .mar_enable(mar_enable),
        .mdr_enable(mdr_enable),
        .mdr_read(mdr_read),
        .m_data_in(m_data_in),
        .y_data(y_data),
        .hi_data(hi_data),
        .lo_data(lo_data),
        .pc_data(pc_data),
        .mar_data(mar_data),
        .mdr_data(mdr_data)
    );

    // Y is operand a, the bus is operand b
    mul_div_alu alu_i (
        .clk(clk),
        .rst_n(rst_n),
        .op_code(op_code),
        .a_data(y_data),
        .b_data(bus_data),
        .z_enable(z_enable),
        .zhi_data(zhi_data),
        .zlo_data(zlo_data),
        .alu_busy(alu_busy)
    );

endmodule

// ==== design/mul_div_alu.sv ====
module mul_div_alu (
    input  logic clk,
    input  logic rst_n,
    input  alu_pkg::alu_op_e op_code,
    input  logic [bus_pkg::DATA_WIDTH-1:0] a_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] b_data,
    input  logic z_enable,
    output logic [bus_pkg::DATA_WIDTH-1:0] zhi_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] zlo_data,
    output logic alu_busy
);

    localparam int W = bus_pkg::DATA_WIDTH;
    localparam int STEP_W = $clog2(W);

    logic [W-1:0] simple_result;
    alu_pkg::z_word_u z_next;
    alu_pkg::z_word_u z_q;
    alu_pkg::z_word_u div_final;
    logic div_start;
    logic [W-1:0] a_mag;
    logic [W-1:0] b_mag;

    // divider state
    logic [STEP_W-1:0] step_cnt;
    logic [W-1:0] rem_q;
    logic [W-1:0] quo_q;
    logic [W-1:0] divisor_q;
    logic dividend_neg_q;
    logic quotient_neg_q;
    logic div_zero_q;
    logic [W:0] rem_shift;
    logic [W:0] rem_diff;
    logic [W-1:0] rem_step;
    logic [W-1:0] quo_step;

    always_comb begin
        case (op_code)
            alu_pkg::OP_ADD: simple_result = a_data + b_data;
            alu_pkg::OP_SUB: simple_result = a_data - b_data;
            alu_pkg::OP_AND: simple_result = a_data & b_data;
            alu_pkg::OP_OR: simple_result = a_data | b_data;
            alu_pkg::OP_SHL: simple_result = a_data << b_data[STEP_W-1:0];
            alu_pkg::OP_SHR: simple_result = a_data >> b_data[STEP_W-1:0];
            alu_pkg::OP_NEG: simple_result = -b_data;
            alu_pkg::OP_NOT: simple_result = ~b_data;
            default: simple_result = '0;
        endcase
    end

    // single-cycle ops clear ZHI, multiply fills both halves
    always_comb begin
        if (op_code == alu_pkg::OP_MUL) begin
            z_next.product = $signed(a_data) * $signed(b_data);
        end else begin
            z_next.product = {{W{1'b0}}, simple_result};
        end
    end

    assign div_start = z_enable && !alu_busy && (op_code == alu_pkg::OP_DIV);
    assign a_mag = a_data[W-1] ? -a_data : a_data;
    assign b_mag = b_data[W-1] ? -b_data : b_data;

    // one restoring step, next quotient bit comes from the dividend top
    always_comb begin
        rem_shift = {rem_q, quo_q[W-1]};
        rem_diff = rem_shift - {1'b0, divisor_q};
        if (rem_shift >= {1'b0, divisor_q}) begin
            rem_step = rem_diff[W-1:0];
            quo_step = {quo_q[W-2:0], 1'b1};
        end else begin
            rem_step = rem_shift[W-1:0];
            quo_step = {quo_q[W-2:0], 1'b0};
        end
    end

    // remainder takes the dividend's sign
    always_comb begin
        div_final.divres.remainder = dividend_neg_q ? -rem_step : rem_step;
        if (div_zero_q) begin
            div_final.divres.quotient = '1;
        end else begin
            div_final.divres.quotient = quotient_neg_q ? -quo_step : quo_step;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            z_q <= '0;
            alu_busy <= 1'b0;
            step_cnt <= '0;
        end else if (alu_busy) begin
            step_cnt <= step_cnt + 1'b1;
            // Z is written on the edge where busy drops
            if (step_cnt == STEP_W'(W - 1)) begin
                alu_busy <= 1'b0;
                z_q <= div_final;
            end
        end else if (div_start) begin
            alu_busy <= 1'b1;
            step_cnt <= '0;
        end else if (z_enable) begin
            z_q <= z_next;
        end
    end

    // working registers, loaded with magnitudes at start
    always_ff @(posedge clk) begin
        if (alu_busy) begin
            rem_q <= rem_step;
            quo_q <= quo_step;
        end else if (div_start) begin
            rem_q <= '0;
            quo_q <= a_mag;
            divisor_q <= b_mag;
            dividend_neg_q <= a_data[W-1];
            quotient_neg_q <= a_data[W-1] ^ b_data[W-1];
            div_zero_q <= (b_data == '0);
        end
    end

    assign zhi_data = z_q.product[2*W-1:W];
    assign zlo_data = z_q.product[W-1:0];

endmodule

// ==== design/special_regs.sv ====
module special_regs (
    input  logic clk,
    input  logic rst_n,
    input  logic [bus_pkg::DATA_WIDTH-1:0] bus_data,
    input  logic y_enable,
    input  logic hi_enable,
    input  logic lo_enable,
    input  logic pc_enable,
    input  logic pc_increment,
    input  logic mar_enable,
    input  logic mdr_enable,
    input  logic mdr_read,
    input  logic [bus_pkg::DATA_WIDTH-1:0] m_data_in,
    output logic [bus_pkg::DATA_WIDTH-1:0] y_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] hi_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] lo_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] pc_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] mar_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] mdr_data
);

    // byte step between instruction words
    localparam logic [bus_pkg::DATA_WIDTH-1:0] PC_STEP = bus_pkg::DATA_WIDTH'(4);

    logic [bus_pkg::DATA_WIDTH-1:0] mdr_in;
    logic [bus_pkg::DATA_WIDTH-1:0] pc_next;

    // memory side when reading, bus side otherwise
    assign mdr_in = mdr_read ? m_data_in : bus_data;

    // a bus load takes priority over the increment
    always_comb begin
        if (pc_enable) begin
            pc_next = bus_data;
        end else if (pc_increment) begin
            pc_next = pc_data + PC_STEP;
        end else begin
            pc_next = pc_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            y_data <= '0;
            hi_data <= '0;
            lo_data <= '0;
        end else begin
            if (y_enable) begin
                y_data <= bus_data;
            end
            if (hi_enable) begin
                hi_data <= bus_data;
            end
            if (lo_enable) begin
                lo_data <= bus_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_data <= '0;
        end else begin
            pc_data <= pc_next;
        end
    end

    // memory interface registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar_data <= '0;
            mdr_data <= '0;
        end else begin
            if (mar_enable) begin
                mar_data <= bus_data;
            end
            if (mdr_enable) begin
                mdr_data <= mdr_in;
            end
        end
    end

endmodule

// ==== design/bus_mux.sv ====
module bus_mux #(
    parameter int NUM_GP_REGS = bus_pkg::MAX_GP_REGS
) (
    input  logic [bus_pkg::DATA_WIDTH-1:0] slice_out [NUM_GP_REGS],
    input  logic [bus_pkg::DATA_WIDTH-1:0] hi_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] lo_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] zhi_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] zlo_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] pc_data,
    input  logic [bus_pkg::DATA_WIDTH-1:0] mdr_data,
    input  bus_pkg::bus_src_e bus_src,
    output logic [bus_pkg::DATA_WIDTH-1:0] bus_data
);

    logic [bus_pkg::DATA_WIDTH-1:0] gp_data;
    logic [bus_pkg::DATA_WIDTH-1:0] special_data;

    // at most one slice is non-zero
    always_comb begin
        gp_data = '0;
        for (int i = 0; i < NUM_GP_REGS; i++) begin
            gp_data = gp_data | slice_out[i];
        end
    end

    // special sources; register codes and SRC_NONE fall to zero
    always_comb begin
        case (bus_src)
            bus_pkg::SRC_HI: special_data = hi_data;
            bus_pkg::SRC_LO: special_data = lo_data;
            bus_pkg::SRC_ZHI: special_data = zhi_data;
            bus_pkg::SRC_ZLO: special_data = zlo_data;
            bus_pkg::SRC_PC: special_data = pc_data;
            bus_pkg::SRC_MDR: special_data = mdr_data;
            default: special_data = '0;
        endcase
    end

    assign bus_data = gp_data | special_data;

endmodule

// ==== design/gp_reg_slice.sv ====
module gp_reg_slice #(
    parameter int unsigned REG_INDEX = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_en,
    input  logic [bus_pkg::GP_ADDR_WIDTH-1:0] wr_addr,
    input  bus_pkg::bus_src_e bus_src,
    input  logic [bus_pkg::DATA_WIDTH-1:0] bus_data,
    output logic [bus_pkg::DATA_WIDTH-1:0] slice_out
);

    // own write address and own bus-source code
    localparam logic [bus_pkg::GP_ADDR_WIDTH-1:0] SLICE_ADDR =
        bus_pkg::GP_ADDR_WIDTH'(REG_INDEX);
    localparam bus_pkg::bus_src_e SLICE_SRC = bus_pkg::bus_src_e'(REG_INDEX);

    logic [bus_pkg::DATA_WIDTH-1:0] reg_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_q <= '0;
        end else if (wr_en && (wr_addr == SLICE_ADDR)) begin
            reg_q <= bus_data;
        end
    end

    // masked here so the bus mux can simply OR the slices
    assign slice_out = (bus_src == SLICE_SRC) ? reg_q : '0;

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

    // alu operation select
    typedef enum logic [4:0] {
        OP_ADD = 5'd0,
        OP_SUB = 5'd1,
        OP_AND = 5'd2,
        OP_OR = 5'd3,
        // shifts take the amount from the low bits of b
        OP_SHL = 5'd4,
        OP_SHR = 5'd5,
        // neg and not work on b alone
        OP_NEG = 5'd6,
        OP_NOT = 5'd7,
        OP_MUL = 5'd8,
        // multi-cycle, reported by alu_busy
        OP_DIV = 5'd9
    } alu_op_e;

    // divide result layout inside Z
    typedef struct packed {
        logic [bus_pkg::DATA_WIDTH-1:0] remainder;
        logic [bus_pkg::DATA_WIDTH-1:0] quotient;
    } div_result_t;

    // the 64-bit Z word
    // multiply writes the full product, divide writes remainder over quotient
    // upper half shows as ZHI, lower half as ZLO in both views
    typedef union packed {
        logic signed [2*bus_pkg::DATA_WIDTH-1:0] product;
        div_result_t divres;
    } z_word_u;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

    // width of the bus and of every register
    localparam int DATA_WIDTH = 32;

    // size of the general register file and its address width
    localparam int MAX_GP_REGS = 16;
    localparam int GP_ADDR_WIDTH = 4;

    // bus driver select, one code per source
    typedef enum logic [4:0] {
        SRC_R0 = 5'd0,
        SRC_R1 = 5'd1,
        SRC_R2 = 5'd2,
        SRC_R3 = 5'd3,
        SRC_R4 = 5'd4,
        SRC_R5 = 5'd5,
        SRC_R6 = 5'd6,
        SRC_R7 = 5'd7,
        SRC_R8 = 5'd8,
        SRC_R9 = 5'd9,
        SRC_R10 = 5'd10,
        SRC_R11 = 5'd11,
        SRC_R12 = 5'd12,
        SRC_R13 = 5'd13,
        SRC_R14 = 5'd14,
        SRC_R15 = 5'd15,
        SRC_HI = 5'd16,
        SRC_LO = 5'd17,
        SRC_ZHI = 5'd18,
        SRC_ZLO = 5'd19,
        SRC_PC = 5'd20,
        SRC_MDR = 5'd21,
        // nothing drives, bus reads as zero
        SRC_NONE = 5'd22
    } bus_src_e;

endpackage
